// File: fetchPredict_settings.svh
// ==========================================================================
// Fetch predictor sizing, reset PC and RISC-V opcode values
// ==========================================================================
`ifndef FETCHPREDICT_SETTINGS_SVH
`define FETCHPREDICT_SETTINGS_SVH

`define XLEN          32            // Address width
`define BTB_ENTRIES   32
`define BTB_IDX_BITS  5             // PC bits 6..2 select the entry
`define GHR_BITS      5             // Counter table holds 2**GHR_BITS entries

`define PC_START      32'h0000_0000

// Opcodes the predictor cares about
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111

`endif

// File: fetchPredictPkg.sv
// ==========================================================================
// Fetch predictor types: opcode classes and the pipeline, resolve and
// table update records
// ==========================================================================
`default_nettype none
`include "fetchPredict_settings.svh"

package fetchPredictPkg;

    typedef enum logic [1:0] {
        CLASS_OTHER  = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_JUMP   = 2'd2   // JAL and JALR alike
    } opClass_t;

    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        opClass_t             opClass;
        logic                 predTaken;
        logic [`GHR_BITS-1:0] histIdx;  // Counter index used at fetch
    } pipeRec_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic                     btbWe;
        logic [`BTB_IDX_BITS-1:0] btbIdx;
        logic [`XLEN-1:0]         btbData;
        logic                     phtWe;
        logic                     phtInc;    // Count up when the branch was taken
        logic [`GHR_BITS-1:0]     phtIdx;
        logic                     mispredict;
        logic [`XLEN-1:0]         redirectPc;
    } update_t;

    function automatic opClass_t classifyOp(input logic [6:0] op);
        opClass_t cls;
        case (op)
            `OPCODE_BRANCH:             cls = CLASS_BRANCH;
            `OPCODE_JAL, `OPCODE_JALR:  cls = CLASS_JUMP;
            default:                    cls = CLASS_OTHER;
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire

// File: pcGenerator.sv
// ==========================================================================
// Program counter with next-PC selection and the fetch-stage record
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module pcGenerator import fetchPredictPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall_i,
    input  wire logic [6:0]           fetchOp_i,
    input  wire logic                 btbHit_i,
    input  wire logic [`XLEN-1:0]     btbTarget_i,
    input  wire logic                 counterTaken_i,
    input  wire logic [`GHR_BITS-1:0] historyIdx_i,
    input  wire update_t              update_i,
    output logic [`XLEN-1:0]          pc_o,
    output pipeRec_t                  fetchRec_o
);

    opClass_t         fetchClass;
    logic             predTaken;
    logic [`XLEN-1:0] nextPc;

    assign fetchClass = classifyOp(fetchOp_i);

    // A jump only needs a BTB hit, a branch also needs the counter
    assign predTaken = btbHit_i &&
                       ((fetchClass == CLASS_JUMP) ||
                        (fetchClass == CLASS_BRANCH && counterTaken_i));

    always_comb begin
        if (update_i.mispredict)
            nextPc = update_i.redirectPc;
        else if (predTaken)
            nextPc = btbTarget_i;
        else
            nextPc = pc_o + `XLEN'd4;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc_o <= `PC_START;
        else if (update_i.mispredict || !stall_i)   // Redirect wins over stall
            pc_o <= nextPc;
    end

    assign fetchRec_o = '{valid: 1'b1, pc: pc_o, opClass: fetchClass,
                          predTaken: predTaken, histIdx: historyIdx_i};

endmodule

`default_nettype wire

// File: targetBuffer.sv
// ==========================================================================
// Direct-mapped branch target buffer, untagged, with per-entry valid bits
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module targetBuffer import fetchPredictPkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic [`XLEN-1:0] pc_i,
    input  wire update_t          update_i,
    output logic                  hit_o,
    output logic [`XLEN-1:0]      target_o
);

    logic [`BTB_ENTRIES-1:0]  entryValid;
    logic [`XLEN-1:0]         targets [`BTB_ENTRIES];
    logic [`BTB_IDX_BITS-1:0] readIdx;

    // Aliasing PCs share an entry since no tag is kept
    assign readIdx = pc_i[`BTB_IDX_BITS+1:2];

    // Lookup is combinational from the fetch PC
    assign hit_o    = entryValid[readIdx];
    assign target_o = targets[readIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (update_i.btbWe) begin
            entryValid[update_i.btbIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.btbWe)
            targets[update_i.btbIdx] <= update_i.btbData;
    end

endmodule

`default_nettype wire

// File: directionPredictor.sv
// ==========================================================================
// Global history register and the table of 2-bit saturating counters
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module directionPredictor import fetchPredictPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall_i,
    input  wire logic [6:0]           fetchOp_i,
    input  wire update_t              update_i,
    output logic                      counterTaken_o,
    output logic [`GHR_BITS-1:0]      historyIdx_o
);

    localparam int PHT_ENTRIES = 1 << `GHR_BITS;

    logic [`GHR_BITS-1:0] ghr;
    logic [1:0]           counters [PHT_ENTRIES];
    logic                 shiftEn;

    // Table is read at the current history, counter MSB gives the direction
    assign historyIdx_o   = ghr;
    assign counterTaken_o = counters[ghr][1];

    // Every fetched branch shifts, even on a BTB miss
    assign shiftEn = !stall_i && (classifyOp(fetchOp_i) == CLASS_BRANCH);

    always_ff @(posedge clk) begin
        if (reset || update_i.mispredict)
            ghr <= '0;
        else if (shiftEn)
            ghr <= {ghr[`GHR_BITS-2:0], counterTaken_o};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++)
                counters[i] <= 2'b01;   // Weakly not taken
        end else if (update_i.phtWe) begin
            if (update_i.phtInc) begin
                if (counters[update_i.phtIdx] != 2'b11)
                    counters[update_i.phtIdx] <= counters[update_i.phtIdx] + 2'd1;
            end else begin
                if (counters[update_i.phtIdx] != 2'b00)
                    counters[update_i.phtIdx] <= counters[update_i.phtIdx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: branchResolver.sv
// ==========================================================================
// Decode and execute records, prediction check against the actual outcome
// and the table update record
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module branchResolver import fetchPredictPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     stall_i,
    input  wire pipeRec_t fetchRec_i,
    input  wire resolve_t exOutcome_i,
    output update_t       update_o
);

    pipeRec_t decRec;
    pipeRec_t exRec;
    logic     isBranch;
    logic     isJump;
    logic     mispredict;

    always_ff @(posedge clk) begin
        if (reset || mispredict) begin
            decRec.valid <= 1'b0;           // Flush
        end else if (!stall_i) begin
            decRec <= fetchRec_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || mispredict || stall_i) begin
            exRec.valid <= 1'b0;            // Bubble while fetch holds
        end else begin
            exRec <= decRec;
        end
    end

    assign isBranch = exRec.valid && (exRec.opClass == CLASS_BRANCH);
    assign isJump   = exRec.valid && (exRec.opClass == CLASS_JUMP);

    // A jump that fetch did not follow is always a miss
    assign mispredict = (isBranch && (exRec.predTaken != exOutcome_i.taken)) ||
                        (isJump && !exRec.predTaken);

    always_comb begin
        update_o.btbWe      = exRec.valid && (exOutcome_i.taken || isJump);
        update_o.btbIdx     = exRec.pc[`BTB_IDX_BITS+1:2];
        update_o.btbData    = exOutcome_i.target;
        update_o.phtWe      = isBranch;
        update_o.phtInc     = exOutcome_i.taken;
        update_o.phtIdx     = exRec.histIdx;      // Index seen at fetch time
        update_o.mispredict = mispredict;
        update_o.redirectPc = exOutcome_i.taken ? exOutcome_i.target
                                                : exRec.pc + `XLEN'd4;
    end

endmodule

`default_nettype wire

// File: fetchPredict.sv
// ==========================================================================
// Fetch-side branch prediction unit for a single issue slot
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module fetchPredict import fetchPredictPkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             stall_i,
    input  wire logic [6:0]       fetchOp_i,
    input  wire resolve_t         exOutcome_i,
    output logic [`XLEN-1:0]      pc_o,
    output logic                  mispredict_o
);

    logic                 btbHit;
    logic [`XLEN-1:0]     btbTarget;
    logic                 counterTaken;
    logic [`GHR_BITS-1:0] historyIdx;
    pipeRec_t             fetchRec;
    update_t              update;

    pcGenerator pcGen (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .fetchOp_i      (fetchOp_i),
        .btbHit_i       (btbHit),
        .btbTarget_i    (btbTarget),
        .counterTaken_i (counterTaken),
        .historyIdx_i   (historyIdx),
        .update_i       (update),
        .pc_o           (pc_o),
        .fetchRec_o     (fetchRec)
    );

    targetBuffer btb (
        .clk      (clk),
        .reset    (reset),
        .pc_i     (pc_o),
        .update_i (update),
        .hit_o    (btbHit),
        .target_o (btbTarget)
    );

    directionPredictor dirPred (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .fetchOp_i      (fetchOp_i),
        .update_i       (update),
        .counterTaken_o (counterTaken),
        .historyIdx_o   (historyIdx)
    );

    branchResolver resolver (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .fetchRec_i  (fetchRec),
        .exOutcome_i (exOutcome_i),
        .update_o    (update)
    );

    assign mispredict_o = update.mispredict;

endmodule

`default_nettype wire

// File: fetchPredict_checker.sv
// ==========================================================================
// Bound assertions on the fetch predictor top level
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module fetchPredict_checker (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             stall_i,
    input  wire logic [`XLEN-1:0] pc_i,
    input  wire logic             mispredict_i
);

    // Fetch is always one 4-byte word
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    // Stall freezes the PC unless a redirect overrides it
    pcHoldsOnStall: assert property (@(posedge clk) disable iff (reset)
        (stall_i && !mispredict_i) |=> (pc_i == $past(pc_i)))
        else $error("pc_o moved while stalled without a mispredict");

    // Records are invalid out of reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> !mispredict_i)
        else $error("mispredict_o high in the first cycle after reset");

endmodule

bind fetchPredict fetchPredict_checker chk (
    .clk          (clk),
    .reset        (reset),
    .stall_i      (stall_i),
    .pc_i         (pc_o),
    .mispredict_i (mispredict_o)
);

`default_nettype wire

// File: fetchPredict_tb.sv
// ==========================================================================
// Testbench for the fetch predictor: loop program, reference model and
// cycle by cycle comparison of pc_o and mispredict_o
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "fetchPredict_settings.svh"

module fetchPredict_tb import fetchPredictPkg::*; ();

    localparam int          RUN_CYCLES      = 1000;
    localparam int          LIMIT_CYCLES    = 2 * RUN_CYCLES;
    localparam int          DIRECTED_CYCLES = 400;   // Fixed outcomes, no stalls
    localparam logic [31:0] BRANCH_PC  = 32'h20;
    localparam logic [31:0] BRANCH_TGT = 32'h10;
    localparam logic [31:0] JAL_PC     = 32'h40;
    localparam logic [31:0] JAL_TGT    = 32'h80;
    localparam logic [31:0] JALR_PC    = 32'hA4;   // Closes the outer loop
    localparam logic [31:0] JALR_TGT   = 32'h00;

    logic        clk;
    logic        reset;
    logic        stall;
    logic [6:0]  fetchOp;
    resolve_t    exOutcome;
    logic [31:0] pc;
    logic        mispredict;

    // Reference state
    logic [31:0] mPc;
    logic        mBtbValid [32];
    logic [31:0] mBtbTarget [32];
    logic [1:0]  mCounter [32];
    logic [4:0]  mGhr;
    pipeRec_t    mDec;
    pipeRec_t    mEx;

    logic [31:0] randState;
    logic        expMis;
    logic [31:0] lastPc;
    logic        lastMis;
    int          cycleCount;
    int          branchCount;
    int          loopHits;
    int          jumpHits;

    fetchPredict uut (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall),
        .fetchOp_i    (fetchOp),
        .exOutcome_i  (exOutcome),
        .pc_o         (pc),
        .mispredict_o (mispredict)
    );

    function automatic logic [6:0] programOp(input logic [31:0] addr);
        case (addr)
            BRANCH_PC: return `OPCODE_BRANCH;
            JAL_PC:    return `OPCODE_JAL;
            JALR_PC:   return `OPCODE_JALR;
            default:   return 7'b0010011;   // OP-IMM
        endcase
    endfunction

    // Instruction memory answers combinationally at the fetch PC
    assign fetchOp = programOp(pc);

    function automatic opClass_t classOf(input logic [6:0] op);
        if (op == `OPCODE_BRANCH)
            return CLASS_BRANCH;
        if (op == `OPCODE_JAL || op == `OPCODE_JALR)
            return CLASS_JUMP;
        return CLASS_OTHER;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic expectedMispredict(input resolve_t res);
        if (!mEx.valid)
            return 1'b0;
        if (mEx.opClass == CLASS_BRANCH)
            return mEx.predTaken != res.taken;
        return (mEx.opClass == CLASS_JUMP) && !mEx.predTaken;
    endfunction

    task automatic resetModel();
        mPc  = `PC_START;
        mGhr = '0;
        mDec = '0;
        mEx  = '0;
        for (int i = 0; i < 32; i++) begin
            mBtbValid[i] = 1'b0;
            mCounter[i]  = 2'b01;   // Weakly not taken
        end
    endtask

    // Steps the model by one clock edge from the state before the edge
    function automatic void advanceModel(input logic stallIn, input resolve_t res);
        logic        mis;
        logic        pred;
        logic        ctrBit;
        logic [31:0] tgt;
        opClass_t    cls;
        pipeRec_t    fetched;
        mis     = expectedMispredict(res);
        cls     = classOf(programOp(mPc));
        ctrBit  = mCounter[mGhr][1];
        tgt     = mBtbTarget[mPc[6:2]];
        pred    = mBtbValid[mPc[6:2]] &&
                  (cls == CLASS_JUMP || (cls == CLASS_BRANCH && ctrBit));
        fetched = '{valid: 1'b1, pc: mPc, opClass: cls, predTaken: pred, histIdx: mGhr};
        if (mEx.valid && (res.taken || mEx.opClass == CLASS_JUMP)) begin
            mBtbValid[mEx.pc[6:2]]  = 1'b1;
            mBtbTarget[mEx.pc[6:2]] = res.target;
        end
        if (mEx.valid && mEx.opClass == CLASS_BRANCH) begin
            if (res.taken && mCounter[mEx.histIdx] != 2'd3)
                mCounter[mEx.histIdx] = mCounter[mEx.histIdx] + 2'd1;
            else if (!res.taken && mCounter[mEx.histIdx] != 2'd0)
                mCounter[mEx.histIdx] = mCounter[mEx.histIdx] - 2'd1;
        end
        if (mis) begin
            mPc       = res.taken ? res.target : mEx.pc + 32'd4;
            mGhr      = '0;
            mDec.valid = 1'b0;
            mEx.valid  = 1'b0;
        end else if (stallIn) begin
            mEx.valid = 1'b0;       // Bubble into execute
        end else begin
            if (cls == CLASS_BRANCH)
                mGhr = {mGhr[3:0], ctrBit};
            mEx  = mDec;
            mDec = fetched;
            mPc  = pred ? tgt : mPc + 32'd4;
        end
    endfunction

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    // Stall and the outcome of the instruction now in execute
    task automatic driveInputs();
        logic randomPhase;
        logic taken;
        randState   = xorshift(randState);
        randomPhase = cycleCount >= DIRECTED_CYCLES;
        stall       = randomPhase && (randState[2:0] == 3'd0);
        if (mEx.valid && mEx.opClass == CLASS_BRANCH) begin
            taken       = randomPhase ? randState[7] : (branchCount % 7 != 6);
            branchCount = branchCount + 1;
            exOutcome   = '{taken: taken, target: BRANCH_TGT};
        end else if (mEx.valid && mEx.pc == JAL_PC) begin
            exOutcome = '{taken: 1'b1, target: JAL_TGT};
        end else if (mEx.valid && mEx.pc == JALR_PC) begin
            exOutcome = '{taken: 1'b1, target: JALR_TGT};
        end else begin
            exOutcome = '0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= LIMIT_CYCLES)
            stopWithFailure($sformatf("Timeout: run exceeded %0d cycles", LIMIT_CYCLES));
    end

    // Compare in mid cycle, then step the model with the same inputs
    always @(negedge clk) begin
        if (!reset) begin
            expMis = expectedMispredict(exOutcome);
            assert (pc === mPc)
                else stopWithFailure($sformatf("ERROR at %0t ns: pc_o is %h, expected %h",
                                               $time, pc, mPc));
            assert (mispredict === expMis)
                else stopWithFailure($sformatf("ERROR at %0t ns: mispredict_o is %b, expected %b",
                                               $time, mispredict, expMis));
            // DUT fetch went straight to the target with no redirect
            if (lastPc == BRANCH_PC && !lastMis && pc == BRANCH_TGT)
                loopHits = loopHits + 1;
            if (lastPc == JAL_PC && !lastMis && pc == JAL_TGT)
                jumpHits = jumpHits + 1;
            lastPc  = pc;
            lastMis = mispredict;
            advanceModel(stall, exOutcome);
        end
    end

    initial begin
        reset       = 1'b1;
        stall       = 1'b0;
        exOutcome   = '0;
        randState   = 32'd63334;
        lastPc      = `PC_START;
        lastMis     = 1'b0;
        cycleCount  = 0;
        branchCount = 0;
        loopHits    = 0;
        jumpHits    = 0;
        resetModel();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            #1 driveInputs();
        end
        assert (loopHits > 0)
            else stopWithFailure("The trained loop branch was never predicted correctly");
        assert (jumpHits > 0)
            else stopWithFailure("No jump was ever followed from the target buffer");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetchPredict.f
+incdir+.
fetchPredictPkg.sv
pcGenerator.sv
targetBuffer.sv
directionPredictor.sv
branchResolver.sv
fetchPredict.sv
fetchPredict_checker.sv
fetchPredict_tb.sv
